/* tb.f */
logic/memStagePkg.sv
logic/twoWayCache.sv
logic/dataRam.sv
logic/memWriteback.sv
logic/memWriteTop.sv
tb/memWrite_chk.sv
tb/memWriteTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module memWriteTb -f tb.f -o memWriteSim &&
./obj_dir/memWriteSim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* tb/memWriteTb.sv */
`timescale 1ns/1ps

module memWriteTb
    import memStagePkg::*;
;

    localparam int maxCycles = 2000;  // Twice the length of all tests

    logic            clk = 1'b0;
    logic            rstN;
    logic            stall;
    memReq_s         memReq;
    logic [xlen-1:0] readDataM;
    logic            regWriteW;
    logic [4:0]      rdW;
    logic [xlen-1:0] resultW;

    logic [xlen-1:0] refMem [int];  // Reference memory, keyed by word index
    logic [xlen-1:0] expRead;
    logic            checkRead;
    logic            wValid;
    logic            expRegWrite;
    logic [4:0]      expRd;
    logic [xlen-1:0] expResult;

    int errCount    = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int cycleCount  = 0;

    memWriteTop #(
        .numSets  (16),
        .ramWords (256)
    ) DUT (
        .clk_i       (clk),
        .rstN_i      (rstN),
        .stall_i     (stall),
        .memReq_i    (memReq),
        .readDataM_o (readDataM),
        .regWriteW_o (regWriteW),
        .rdW_o       (rdW),
        .resultW_o   (resultW)
    );

    always #5 clk = ~clk;

    // Random word address inside a 64-word window
    function automatic logic [xlen-1:0] randAddr();
        return {24'h0, 6'($urandom_range(0, 63)), 2'b00};
    endfunction

    function automatic logic [xlen-1:0] loadValue(input logic [xlen-1:0] addr, input memOp_e op);
        logic [xlen-1:0] w;
        logic [7:0]      b;
        w = refMem[int'(addr >> 2)];
        b = w[8*int'(addr[1:0]) +: 8];
        case (op)
            byteSigned:   return {{24{b[7]}}, b};
            byteUnsigned: return {24'h0, b};
            default:      return w;
        endcase
    endfunction

    function automatic void applyStore(input memReq_s req);
        logic [xlen-1:0] w;
        int              idx;
        idx = int'(req.aluResult >> 2);
        w   = refMem[idx];
        if (req.memOp == word) begin
            w = req.writeData;
        end else begin
            w[8*int'(req.aluResult[1:0]) +: 8] = req.writeData[7:0];  // Other lanes kept
        end
        refMem[idx] = w;
    endfunction

    function automatic memReq_s makeReq(input resultSrc_e src, input logic wr, input memOp_e op,
                                        input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        memReq_s req;
        req.regWrite  = !wr && 1'($urandom_range(0, 1));
        req.resultSrc = src;
        req.memWrite  = wr;
        req.memOp     = op;
        req.aluResult = addr;
        req.writeData = data;
        req.rd        = 5'($urandom_range(0, 31));
        req.pcPlus4   = $urandom();
        return req;
    endfunction

    function automatic memReq_s makeAluOp();
        resultSrc_e src;
        src = ($urandom_range(0, 1) == 0) ? srcAlu : srcPc4;
        return makeReq(src, 1'b0, word, $urandom(), $urandom());
    endfunction

    function automatic int totalErrors();
        return errCount + DUT.chk.failCount;
    endfunction

    // One request per cycle, placed just after the rising edge
    task automatic issue(input memReq_s req, input logic stallIn);
        @(posedge clk);
        #1;
        memReq    = req;
        stall     = stallIn;
        checkRead = 1'b0;
        if (req.memWrite) begin
            applyStore(req);
        end else if (req.resultSrc == srcMem) begin
            expRead   = loadValue(req.aluResult, req.memOp);
            checkRead = 1'b1;
        end
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        issue(makeReq(srcAlu, 1'b0, word, 32'h0, 32'h0), 1'b0);
        issue(makeReq(srcAlu, 1'b0, word, 32'h0, 32'h0), 1'b0);  // Let the W checks settle
        if (totalErrors() == errsBefore) begin
            testsPassed++;
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, totalErrors() - errsBefore);
        end
    endtask

    task automatic wordAccessTest();
        logic [xlen-1:0] addrs [$];
        logic [xlen-1:0] a;
        int              errsBefore;
        errsBefore = totalErrors();
        for (int i = 0; i < 150; i++) begin
            a = randAddr();
            addrs.push_back(a);
            issue(makeReq(srcAlu, 1'b1, word, a, $urandom()), 1'b0);
        end
        foreach (addrs[i]) begin
            issue(makeReq(srcMem, 1'b0, word, addrs[i], $urandom()), 1'b0);
        end
        reportTest("word store and load", errsBefore);
    endtask

    task automatic byteLaneTest();
        logic [xlen-1:0] a;
        memOp_e          op;
        int              errsBefore;
        errsBefore = totalErrors();
        for (int i = 0; i < 36; i++) begin
            a = randAddr();
            issue(makeReq(srcAlu, 1'b1, word, a, $urandom()), 1'b0);
            for (int lane = 0; lane < 4; lane++) begin
                op = (lane % 2 == 0) ? byteSigned : byteUnsigned;  // Both byte codes store
                issue(makeReq(srcAlu, 1'b1, op, a + 32'(lane), $urandom()), 1'b0);
            end
            issue(makeReq(srcMem, 1'b0, word, a, 32'h0), 1'b0);  // Whole word after merges
            for (int lane = 0; lane < 4; lane++) begin
                issue(makeReq(srcMem, 1'b0, byteSigned, a + 32'(lane), 32'h0), 1'b0);
                issue(makeReq(srcMem, 1'b0, byteUnsigned, a + 32'(lane), 32'h0), 1'b0);
            end
        end
        reportTest("byte lanes", errsBefore);
    endtask

    task automatic resultSelectTest();
        int errsBefore;
        errsBefore = totalErrors();
        for (int i = 0; i < 100; i++) begin
            issue(makeAluOp(), 1'b0);
        end
        reportTest("result select", errsBefore);
    endtask

    // Four tags per set in a two-way cache force evictions
    task automatic setConflictTest();
        logic [3:0] set;
        int         errsBefore;
        errsBefore = totalErrors();
        for (int g = 0; g < 4; g++) begin
            set = 4'($urandom_range(0, 15));
            for (int k = 0; k < 4; k++) begin
                issue(makeReq(srcAlu, 1'b1, word, {24'h0, 2'(k), set, 2'b00}, $urandom()), 1'b0);
            end
            for (int k = 0; k < 4; k++) begin
                issue(makeReq(srcMem, 1'b0, word, {24'h0, 2'(k), set, 2'b00}, 32'h0), 1'b0);
            end
        end
        reportTest("set conflicts", errsBefore);
    endtask

    task automatic stallTest();
        logic [xlen-1:0] a;
        int              errsBefore;
        errsBefore = totalErrors();
        for (int r = 0; r < 3; r++) begin
            a = randAddr();
            issue(makeReq(srcAlu, 1'b1, word, a, $urandom()), 1'b0);
            issue(makeReq(srcMem, 1'b0, word, a, 32'h0), 1'b0);
            for (int i = 0; i < 4; i++) begin
                issue(makeAluOp(), 1'b1);
            end
            issue(makeAluOp(), 1'b0);
            issue(makeAluOp(), 1'b0);
        end
        reportTest("stall hold", errsBefore);
    endtask

    // Expected W stage, one edge behind the request
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wValid      <= 1'b0;
            expRegWrite <= 1'b0;
            expRd       <= '0;
            expResult   <= '0;
        end else if (!stall) begin
            wValid      <= 1'b1;
            expRegWrite <= memReq.regWrite;
            expRd       <= memReq.rd;
            case (memReq.resultSrc)
                srcMem:  expResult <= expRead;
                srcPc4:  expResult <= memReq.pcPlus4;
                default: expResult <= memReq.aluResult;
            endcase
        end
    end

    always @(negedge clk) begin
        if (checkRead) begin
            readMatch: assert (readDataM == expRead) else begin
                errCount++;
                $display("MISMATCH at %0t: readDataM_o expected %h, actual %h",
                         $time, expRead, readDataM);
            end
        end
        if (wValid) begin
            resultMatch: assert (resultW == expResult) else begin
                errCount++;
                $display("MISMATCH at %0t: resultW_o expected %h, actual %h",
                         $time, expResult, resultW);
            end
        end
    end

    regWriteMatch: assert property (@(posedge clk) disable iff (!rstN)
        wValid |-> (regWriteW == expRegWrite)) else begin
        errCount++;
        $display("MISMATCH at %0t: regWriteW_o expected %0b, actual %0b",
                 $time, $sampled(expRegWrite), $sampled(regWriteW));
    end

    rdMatch: assert property (@(posedge clk) disable iff (!rstN)
        wValid |-> (rdW == expRd)) else begin
        errCount++;
        $display("MISMATCH at %0t: rdW_o expected %0d, actual %0d",
                 $time, $sampled(expRd), $sampled(rdW));
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", maxCycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h446d));
        rstN            = 1'b0;
        stall           = 1'b0;
        memReq          = '0;
        memReq.regWrite = 1'b1;  // Reset has to hold the W register clear against this
        expRead         = '0;
        checkRead       = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        wordAccessTest();
        byteLaneTest();
        resultSelectTest();
        setConflictTest();
        stallTest();
        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && totalErrors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tb/memWrite_chk.sv */
`timescale 1ns/1ps

module memWriteChk
    import memStagePkg::*;
(
    input logic            clk_i,
    input logic            rstN_i,
    input logic            stall_i,
    input memReq_s         memReq_i,
    input logic            regWriteW_i,
    input logic [4:0]      rdW_i,
    input logic [xlen-1:0] resultW_i
);

    int failCount = 0;  // Read by the testbench

    // W register leaves reset empty
    resetClears: assert property (@(posedge clk_i) $rose(rstN_i) |-> !regWriteW_i) else begin
        failCount++;
        $error("regWriteW_o high in the first cycle after reset");
    end

    stallHolds: assert property (@(posedge clk_i) disable iff (!rstN_i)
        stall_i |=> $stable(regWriteW_i) && $stable(rdW_i) && $stable(resultW_i)) else begin
        failCount++;
        $error("W outputs changed while stalled");
    end

    rdTracks: assert property (@(posedge clk_i) disable iff (!rstN_i)
        !stall_i |=> (rdW_i == $past(memReq_i.rd))) else begin
        failCount++;
        $error("rdW_o does not follow the previous request");
    end

endmodule

bind memWriteTop memWriteChk chk (
    .clk_i       (clk_i),
    .rstN_i      (rstN_i),
    .stall_i     (stall_i),
    .memReq_i    (memReq_i),
    .regWriteW_i (regWriteW_o),
    .rdW_i       (rdW_o),
    .resultW_i   (resultW_o)
);

/* logic/memWriteTop.sv */
`timescale 1ns/1ps

module memWriteTop
    import memStagePkg::*;
#(
    parameter int numSets  = 16,
    parameter int ramWords = 256
) (
    input  logic            clk_i,
    input  logic            rstN_i,
    input  logic            stall_i,
    input  memReq_s         memReq_i,

    output logic [xlen-1:0] readDataM_o,  // Forwarded back to execute

    output logic            regWriteW_o,
    output logic [4:0]      rdW_o,
    output logic [xlen-1:0] resultW_o
);

    // Cache to RAM port
    logic [xlen-1:0] ramRdata;
    logic [xlen-1:0] ramRaddr;
    logic            ramWe;
    logic [xlen-1:0] ramWaddr;
    logic [xlen-1:0] ramWdata;

    twoWayCache #(
        .numSets (numSets)
    ) uCache (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .memReq_i   (memReq_i),
        .readData_o (readDataM_o),
        .ramRdata_i (ramRdata),
        .ramRaddr_o (ramRaddr),
        .ramWe_o    (ramWe),
        .ramWaddr_o (ramWaddr),
        .ramWdata_o (ramWdata)
    );

    dataRam #(
        .ramWords (ramWords)
    ) uRam (
        .clk_i   (clk_i),
        .raddr_i (ramRaddr),
        .rdata_o (ramRdata),
        .we_i    (ramWe),
        .waddr_i (ramWaddr),
        .wdata_i (ramWdata)
    );

    memWriteback uWriteback (
        .clk_i       (clk_i),
        .rstN_i      (rstN_i),
        .stall_i     (stall_i),  // Freezes only the W register
        .memReq_i    (memReq_i),
        .readData_i  (readDataM_o),
        .regWriteW_o (regWriteW_o),
        .rdW_o       (rdW_o),
        .resultW_o   (resultW_o)
    );

endmodule

/* logic/memWriteback.sv */
`timescale 1ns/1ps

module memWriteback
    import memStagePkg::*;
(
    input  logic            clk_i,
    input  logic            rstN_i,
    input  logic            stall_i,
    input  memReq_s         memReq_i,
    input  logic [xlen-1:0] readData_i,
    output logic            regWriteW_o,
    output logic [4:0]      rdW_o,
    output logic [xlen-1:0] resultW_o
);

    wbStage_s wbD;
    wbStage_s wbQ;

    // Pick the fields that survive into writeback
    always_comb begin
        wbD.regWrite  = memReq_i.regWrite;
        wbD.resultSrc = memReq_i.resultSrc;
        wbD.aluResult = memReq_i.aluResult;
        wbD.readData  = readData_i;
        wbD.rd        = memReq_i.rd;
        wbD.pcPlus4   = memReq_i.pcPlus4;
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            wbQ <= '0;  // resultSrc clears to srcAlu
        end else if (!stall_i) begin
            wbQ <= wbD;
        end
    end

    assign regWriteW_o = wbQ.regWrite;
    assign rdW_o       = wbQ.rd;

    // Result select
    always_comb begin
        case (wbQ.resultSrc)
            srcMem:  resultW_o = wbQ.readData;
            srcPc4:  resultW_o = wbQ.pcPlus4;
            default: resultW_o = wbQ.aluResult;
        endcase
    end

endmodule

/* logic/dataRam.sv */
`timescale 1ns/1ps

module dataRam
    import memStagePkg::*;
#(
    parameter int ramWords = 256
) (
    input  logic            clk_i,
    input  logic [xlen-1:0] raddr_i,
    output logic [xlen-1:0] rdata_o,
    input  logic            we_i,
    input  logic [xlen-1:0] waddr_i,
    input  logic [xlen-1:0] wdata_i
);

    localparam int addrBits = $clog2(ramWords);

    logic [xlen-1:0]     mem [ramWords];
    logic [addrBits-1:0] rdIdx;
    logic [addrBits-1:0] wrIdx;

    // Word index, byte offset bits dropped
    assign rdIdx = raddr_i[2 +: addrBits];
    assign wrIdx = waddr_i[2 +: addrBits];

    assign rdata_o = mem[rdIdx];  // Asynchronous read

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[wrIdx] <= wdata_i;
        end
    end

endmodule

/* logic/twoWayCache.sv */
`timescale 1ns/1ps

module twoWayCache
    import memStagePkg::*;
#(
    parameter int numSets = 16
) (
    input  logic            clk_i,
    input  logic            rstN_i,
    input  memReq_s         memReq_i,
    output logic [xlen-1:0] readData_o,
    input  logic [xlen-1:0] ramRdata_i,
    output logic [xlen-1:0] ramRaddr_o,
    output logic            ramWe_o,
    output logic [xlen-1:0] ramWaddr_o,
    output logic [xlen-1:0] ramWdata_o
);

    localparam int setBits = $clog2(numSets);
    localparam int tagBits = xlen - 2 - setBits;  // Word offset takes the low two bits

    // Line storage, one word per way
    logic [tagBits-1:0] tagArr   [numSets][2];
    logic [xlen-1:0]    dataArr  [numSets][2];
    logic [1:0]         validArr [numSets];
    logic               lruArr   [numSets];  // Way to replace next

    logic               accessEn;
    logic [setBits-1:0] setIdx;
    logic [tagBits-1:0] reqTag;
    logic [1:0]         byteOff;
    logic               isByteOp;

    logic               hit0;
    logic               hit1;
    logic               hit;
    logic               hitWay;
    logic               fillWay;

    memWord_u           curWord;
    memWord_u           mergeWord;
    logic [7:0]         loadByte;
    logic [xlen-1:0]    alignedAddr;

    // Only loads and stores touch the cache, so ALU ops cannot evict lines
    assign accessEn = (memReq_i.resultSrc == srcMem) || memReq_i.memWrite;

    assign setIdx   = memReq_i.aluResult[2 +: setBits];
    assign reqTag   = memReq_i.aluResult[xlen-1 -: tagBits];
    assign byteOff  = memReq_i.aluResult[1:0];
    assign isByteOp = (memReq_i.memOp == byteSigned) || (memReq_i.memOp == byteUnsigned);

    assign alignedAddr = {memReq_i.aluResult[xlen-1:2], 2'b00};

    // Tag compare on both ways
    assign hit0    = validArr[setIdx][0] && (tagArr[setIdx][0] == reqTag);
    assign hit1    = validArr[setIdx][1] && (tagArr[setIdx][1] == reqTag);
    assign hit     = hit0 || hit1;
    assign hitWay  = hit1;
    assign fillWay = hit ? hitWay : lruArr[setIdx];  // Miss replaces the LRU way

    // Current word comes from the hit way, else straight from the RAM
    always_comb begin
        if (hit) begin
            curWord.whole = dataArr[setIdx][hitWay];
        end else begin
            curWord.whole = ramRdata_i;
        end
    end

    // Load path
    assign loadByte = curWord.lane[byteOff];

    always_comb begin
        case (memReq_i.memOp)
            byteSigned:   readData_o = {{(xlen-8){loadByte[7]}}, loadByte};
            byteUnsigned: readData_o = {{(xlen-8){1'b0}}, loadByte};
            default:      readData_o = curWord.whole;
        endcase
    end

    // Store path, byte merged into the current word
    always_comb begin
        mergeWord = curWord;
        if (isByteOp) begin
            mergeWord.lane[byteOff] = memReq_i.writeData[7:0];
        end else begin
            mergeWord.whole = memReq_i.writeData;
        end
    end

    // Write-through port to the RAM
    assign ramRaddr_o = alignedAddr;  // Always word aligned
    assign ramWe_o    = accessEn && memReq_i.memWrite;
    assign ramWaddr_o = alignedAddr;
    assign ramWdata_o = mergeWord.whole;

    // Valid and LRU state
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int s = 0; s < numSets; s++) begin
                validArr[s] <= 2'b00;
                lruArr[s]   <= 1'b0;
            end
        end else if (accessEn) begin
            validArr[setIdx][fillWay] <= 1'b1;
            lruArr[setIdx]            <= ~fillWay;  // Other way is now least recent
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk_i) begin
        if (accessEn) begin
            if (memReq_i.memWrite) begin
                dataArr[setIdx][fillWay] <= mergeWord.whole;
                tagArr[setIdx][fillWay]  <= reqTag;
            end else if (!hit) begin
                dataArr[setIdx][fillWay] <= ramRdata_i;  // Line fill on load miss
                tagArr[setIdx][fillWay]  <= reqTag;
            end
        end
    end

endmodule

/* logic/memStagePkg.sv */
package memStagePkg;

    parameter int xlen = 32;  // RV32 data width

    // Access width, encoded as in the load/store funct3 field
    typedef enum logic [2:0] {
        byteSigned   = 3'b000,
        word         = 3'b010,
        byteUnsigned = 3'b100
    } memOp_e;

    typedef enum logic [1:0] {
        srcAlu = 2'b00,  // ALU result
        srcMem = 2'b01,  // Loaded data
        srcPc4 = 2'b10   // Link address for jumps
    } resultSrc_e;

    // One memory word, seen either whole or as byte lanes
    typedef union packed {
        logic [xlen-1:0] whole;
        logic [3:0][7:0] lane;  // Lane 0 is the least significant byte
    } memWord_u;

    // Bundle handed over by the execute stage
    typedef struct packed {
        logic            regWrite;
        resultSrc_e      resultSrc;
        logic            memWrite;
        memOp_e          memOp;
        logic [xlen-1:0] aluResult;  // Also the data address
        logic [xlen-1:0] writeData;
        logic [4:0]      rd;
        logic [xlen-1:0] pcPlus4;
    } memReq_s;

    // Contents of the memory-to-writeback register
    typedef struct packed {
        logic            regWrite;
        resultSrc_e      resultSrc;
        logic [xlen-1:0] aluResult;
        logic [xlen-1:0] readData;
        logic [4:0]      rd;
        logic [xlen-1:0] pcPlus4;
    } wbStage_s;

endpackage
